// File: verif/mem_ctrl_vectors.txt
// All words hex. First word: number of runs
// Per run: ready_high ready_low random_gap w_count w_sum if_count if_sum of_count of_sum
5
// Steady pattern, short low gaps
0e 03 0 90 2838 240 4fe0 240 22e0
// Ready toggling every cycle
01 01 0 90 2838 240 4fe0 240 22e0
// Ready held high until the layer's writes are done
28 00 0 90 2838 240 4fe0 240 22e0
// Random low gaps up to ready_low cycles
05 06 1 90 2838 240 4fe0 240 22e0
10 0c 1 90 2838 240 4fe0 240 22e0

// File: compile.f
common/mem_ctrl_pkg.sv
fetch/weight_addr_gen.sv
fetch/ifmap_addr_gen.sv
fetch/fetch_sequencer.sv
writeback/ofmap_writer.sv
source/mem_ctrl_top.sv
verif/mem_ctrl_assertions.sv
verif/tb_mem_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mem_ctrl testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_mem_ctrl \
    -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mem_ctrl)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_mem_ctrl.sv
`timescale 1ns/1ps

module tb_mem_ctrl;

    typedef enum {M_IDLE, M_WEIGHT, M_IFMAP, M_WAIT} model_phase_t;

    logic                 clk = 1'b0;
    logic                 rstn;
    logic                 i_start;
    logic                 i_ofmap_ready;
    mem_ctrl_pkg::w_rd_t  o_w_rd;
    mem_ctrl_pkg::if_rd_t o_if_rd;
    mem_ctrl_pkg::of_wr_t o_of_wr;
    logic                 o_mac_done;

    logic [31:0]  vec_mem [0:63];
    integer       seed = 29;
    model_phase_t phase;
    int           row;
    int           pass;
    int           pix;
    int           wr_n;       // Ofmap writes since reset
    int           hi_left;
    int           lo_left;
    int           w_cnt;
    int           w_sum;
    int           if_cnt;
    int           if_sum;
    int           of_cnt;
    int           of_sum;
    int           done_cnt;

    always #20 clk = ~clk;

    mem_ctrl_top dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_start       (i_start),
        .i_ofmap_ready (i_ofmap_ready),
        .o_w_rd        (o_w_rd),
        .o_if_rd       (o_if_rd),
        .o_of_wr       (o_of_wr),
        .o_mac_done    (o_mac_done)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_w_rd(input mem_ctrl_pkg::w_rd_t got, input mem_ctrl_pkg::w_rd_t exp);
        if (got.rd_en !== exp.rd_en || got.prefetch !== exp.prefetch
                || (exp.rd_en && got.addr !== exp.addr)) begin
            stop_on_error($sformatf(
                "MISMATCH time %0t o_w_rd: got %0b,%0b,%0d expected %0b,%0b,%0d",
                $time, got.rd_en, got.prefetch, got.addr, exp.rd_en, exp.prefetch, exp.addr));
        end
    endtask

    task automatic check_if_rd(input mem_ctrl_pkg::if_rd_t got, input mem_ctrl_pkg::if_rd_t exp);
        if (got.rd_en !== exp.rd_en || got.start !== exp.start
                || (exp.rd_en && got.addr !== exp.addr)) begin
            stop_on_error($sformatf(
                "MISMATCH time %0t o_if_rd: got %0b,%0b,%0d expected %0b,%0b,%0d",
                $time, got.rd_en, got.start, got.addr, exp.rd_en, exp.start, exp.addr));
        end
    endtask

    task automatic check_of_wr(input mem_ctrl_pkg::of_wr_t got, input mem_ctrl_pkg::of_wr_t exp);
        if (got.wr_en !== exp.wr_en || got.wr_done !== exp.wr_done
                || (exp.wr_en && got.addr !== exp.addr)) begin
            stop_on_error($sformatf(
                "MISMATCH time %0t o_of_wr: got %0b,%0b,%0d expected %0b,%0b,%0d",
                $time, got.wr_en, got.wr_done, got.addr, exp.wr_en, exp.wr_done, exp.addr));
        end
    endtask

    task automatic check_total(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("MISMATCH time %0t %s: got %0d expected %0d",
                $time, name, got, exp));
        end
    endtask

    function automatic int layer_writes();
        return mem_ctrl_pkg::KERNEL_STEPS * mem_ctrl_pkg::OC_TILES * mem_ctrl_pkg::PIXELS;
    endfunction

    function automatic mem_ctrl_pkg::w_addr_t weight_addr(input int p, input int r);
        int oc;
        int step;
        oc   = p % mem_ctrl_pkg::OC_TILES;
        step = p / mem_ctrl_pkg::OC_TILES;
        return mem_ctrl_pkg::w_addr_t'(r * mem_ctrl_pkg::WT_ROW_STRIDE + oc
            + step * mem_ctrl_pkg::WT_STEP_STRIDE);
    endfunction

    // Pass index nests oc tile, ic tile, kx, ky from innermost
    function automatic mem_ctrl_pkg::if_addr_t ifmap_addr(input int p, input int n);
        int x;
        int y;
        int ic;
        int kx;
        int ky;
        x  = n % mem_ctrl_pkg::OFMAP_W;
        y  = n / mem_ctrl_pkg::OFMAP_W;
        ic = (p / mem_ctrl_pkg::OC_TILES) % mem_ctrl_pkg::IC_TILES;
        kx = (p / (mem_ctrl_pkg::OC_TILES * mem_ctrl_pkg::IC_TILES)) % mem_ctrl_pkg::KERNEL_W;
        ky = p / (mem_ctrl_pkg::OC_TILES * mem_ctrl_pkg::IC_TILES * mem_ctrl_pkg::KERNEL_W);
        return mem_ctrl_pkg::if_addr_t'(x + kx + (y + ky) * mem_ctrl_pkg::IF_ROW_STRIDE
            + ic * mem_ctrl_pkg::IF_TILE_STRIDE);
    endfunction

    function automatic mem_ctrl_pkg::of_addr_t ofmap_addr(input int n);
        int px;
        int oc;
        px = n % mem_ctrl_pkg::PIXELS;
        oc = (n / mem_ctrl_pkg::PIXELS) % mem_ctrl_pkg::OC_TILES;
        return mem_ctrl_pkg::of_addr_t'(px * mem_ctrl_pkg::OF_PIX_STRIDE + oc);
    endfunction

    task automatic run_cycle(input logic start, input logic ready);
        mem_ctrl_pkg::w_rd_t  exp_w;
        mem_ctrl_pkg::if_rd_t exp_if;
        mem_ctrl_pkg::of_wr_t exp_of;
        logic                 exp_done;
        @(negedge clk);
        i_start       = start;
        i_ofmap_ready = ready;
        #10;  // Mid low phase, outputs settled
        exp_w    = '0;
        exp_if   = '0;
        exp_of   = '0;
        exp_done = 1'b0;
        case (phase)
            M_WEIGHT: begin
                exp_w.rd_en    = 1'b1;
                exp_w.prefetch = row == 0;
                exp_w.addr     = weight_addr(pass, row);
            end
            M_IFMAP: begin
                exp_if.rd_en = 1'b1;
                exp_if.start = pix == 0;
                exp_if.addr  = ifmap_addr(pass, pix);
                exp_done     = pass == mem_ctrl_pkg::PASSES - 1 && pix == mem_ctrl_pkg::PIXELS - 1;
            end
            M_WAIT: begin
                if (!ready) begin  // Next tile only once ready drops
                    exp_w.rd_en    = 1'b1;
                    exp_w.prefetch = 1'b1;
                    exp_w.addr     = weight_addr(pass, 0);
                end
            end
            default: begin
            end
        endcase
        if (ready) begin
            exp_of.wr_en   = 1'b1;
            exp_of.wr_done = wr_n % layer_writes() == layer_writes() - 1;
            exp_of.addr    = ofmap_addr(wr_n);
        end
        check_w_rd(o_w_rd, exp_w);
        check_if_rd(o_if_rd, exp_if);
        check_of_wr(o_of_wr, exp_of);
        check_total("o_mac_done", int'(o_mac_done), int'(exp_done));
        if (o_w_rd.rd_en) begin
            w_cnt++;
            w_sum += int'(o_w_rd.addr);
        end
        if (o_if_rd.rd_en) begin
            if_cnt++;
            if_sum += int'(o_if_rd.addr);
        end
        if (o_of_wr.wr_en) begin
            of_cnt++;
            of_sum += int'(o_of_wr.addr);
        end
        if (o_mac_done) done_cnt++;
        if (phase == M_IDLE && start) begin
            phase = M_WEIGHT;
            row   = 0;
            pass  = 0;
            pix   = 0;
        end else if (exp_w.rd_en) begin
            if (row == mem_ctrl_pkg::MAC_ROW - 1) begin
                phase = M_IFMAP;
                pix   = 0;
            end else begin
                row++;
                phase = M_WEIGHT;
            end
        end else if (exp_if.rd_en) begin
            if (pix < mem_ctrl_pkg::PIXELS - 1) begin
                pix++;
            end else if (pass == mem_ctrl_pkg::PASSES - 1) begin
                phase = M_IDLE;
            end else begin
                pass++;
                row   = 0;
                phase = M_WAIT;
            end
        end
        if (ready) wr_n++;
    endtask

    task automatic next_ready(input int hi_len, input int lo_gap, input logic rnd,
                              output logic ready);
        if (of_cnt >= layer_writes()) begin
            ready = 1'b0;  // All results of the layer written
        end else if (hi_left > 0) begin
            hi_left--;
            ready = 1'b1;
        end else if (lo_left > 0) begin
            lo_left--;
            ready = 1'b0;
        end else begin
            hi_left = hi_len - 1;
            lo_left = rnd ? int'($unsigned($random(seed)) % (lo_gap + 1)) : lo_gap;
            ready   = 1'b1;
        end
    endtask

    task automatic run_layer(input int idx);
        int   base;
        int   hi_len;
        int   lo_gap;
        logic rnd;
        logic ready;
        int   cycles;
        base     = 1 + idx * 9;  // Nine words per run
        hi_len   = int'(vec_mem[base]);
        lo_gap   = int'(vec_mem[base + 1]);
        rnd      = vec_mem[base + 2][0];
        w_cnt    = 0;
        w_sum    = 0;
        if_cnt   = 0;
        if_sum   = 0;
        of_cnt   = 0;
        of_sum   = 0;
        done_cnt = 0;
        hi_left  = 0;
        lo_left  = 0;
        run_cycle(1'b1, 1'b0);
        cycles = 0;
        while (done_cnt == 0) begin
            if (cycles == 4000) begin
                stop_on_error($sformatf("Timeout: o_mac_done never fired in run %0d", idx));
            end
            next_ready(hi_len, lo_gap, rnd, ready);
            run_cycle(1'b0, ready);
            cycles++;
        end
        check_total("ifmap reads at o_mac_done", if_cnt,
            mem_ctrl_pkg::PASSES * mem_ctrl_pkg::PIXELS);
        cycles = 0;
        while (of_cnt < layer_writes()) begin
            if (cycles == 4000) begin
                stop_on_error($sformatf("Timeout: ofmap writes of run %0d never completed", idx));
            end
            next_ready(hi_len, lo_gap, rnd, ready);
            run_cycle(1'b0, ready);
            cycles++;
        end
        repeat (2) run_cycle(1'b0, 1'b0);
        check_total("weight read count", w_cnt, int'(vec_mem[base + 3]));
        check_total("weight address sum", w_sum, int'(vec_mem[base + 4]));
        check_total("ifmap read count", if_cnt, int'(vec_mem[base + 5]));
        check_total("ifmap address sum", if_sum, int'(vec_mem[base + 6]));
        check_total("ofmap write count", of_cnt, int'(vec_mem[base + 7]));
        check_total("ofmap address sum", of_sum, int'(vec_mem[base + 8]));
        check_total("o_mac_done pulses", done_cnt, 1);
    endtask

    initial begin
        int runs;
        rstn          = 1'b0;
        i_start       = 1'b0;
        i_ofmap_ready = 1'b0;
        phase         = M_IDLE;
        row           = 0;
        pass          = 0;
        pix           = 0;
        wr_n          = 0;
        $readmemh("verif/mem_ctrl_vectors.txt", vec_mem);
        runs = int'(vec_mem[0]);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (10) run_cycle(1'b0, 1'b0);  // Quiet outputs without a start
        for (int i = 0; i < runs; i++) begin
            run_layer(i);
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: verif/mem_ctrl_assertions.sv
`timescale 1ns/1ps

module mem_ctrl_assertions (
    input logic                 clk,
    input logic                 rstn,
    input mem_ctrl_pkg::w_rd_t  i_w_rd,
    input mem_ctrl_pkg::if_rd_t i_if_rd,
    input logic                 i_mac_done
);

    // One fetch slot per cycle
    a_one_read: assert property (@(posedge clk) disable iff (!rstn)
        !(i_w_rd.rd_en && i_if_rd.rd_en))
        else $error("Weight and ifmap reads in the same cycle");

    a_prefetch_read: assert property (@(posedge clk) disable iff (!rstn)
        i_w_rd.prefetch |-> i_w_rd.rd_en)
        else $error("Prefetch flag without a weight read");

    a_start_read: assert property (@(posedge clk) disable iff (!rstn)
        i_if_rd.start |-> i_if_rd.rd_en)
        else $error("Ifmap start flag without an ifmap read");

    a_done_read: assert property (@(posedge clk) disable iff (!rstn)
        i_mac_done |-> i_if_rd.rd_en)  // Done rides on the last read
        else $error("Done pulse without an ifmap read");

endmodule

bind fetch_sequencer mem_ctrl_assertions mem_ctrl_assertions_i (
    .clk        (clk),
    .rstn       (rstn),
    .i_w_rd     (o_w_rd),
    .i_if_rd    (o_if_rd),
    .i_mac_done (o_mac_done)
);

// File: source/mem_ctrl_top.sv
`timescale 1ns/1ps

module mem_ctrl_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_start,
    input  logic                 i_ofmap_ready,
    output mem_ctrl_pkg::w_rd_t  o_w_rd,
    output mem_ctrl_pkg::if_rd_t o_if_rd,
    output mem_ctrl_pkg::of_wr_t o_of_wr,
    output logic                 o_mac_done
);

    mem_ctrl_pkg::w_addr_t  w_addr;
    mem_ctrl_pkg::if_addr_t if_addr;
    logic                   w_step;
    logic                   w_clear;
    logic                   w_row_last;
    logic                   if_step;
    logic                   if_window_last;
    logic                   if_layer_last;

    fetch_sequencer fetch_sequencer_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_start          (i_start),
        .i_ofmap_ready    (i_ofmap_ready),
        .i_w_addr         (w_addr),
        .i_w_row_last     (w_row_last),
        .i_if_addr        (if_addr),
        .i_if_window_last (if_window_last),
        .i_if_layer_last  (if_layer_last),
        .o_w_step         (w_step),
        .o_w_clear        (w_clear),
        .o_if_step        (if_step),
        .o_mac_done       (o_mac_done),
        .o_w_rd           (o_w_rd),
        .o_if_rd          (o_if_rd)
    );

    weight_addr_gen weight_addr_gen_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_step     (w_step),
        .i_clear    (w_clear),
        .o_addr     (w_addr),
        .o_row_last (w_row_last)
    );

    ifmap_addr_gen ifmap_addr_gen_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_step        (if_step),
        .o_addr        (if_addr),
        .o_window_last (if_window_last),
        .o_layer_last  (if_layer_last)
    );

    // Write-back runs on its own, paced only by ofmap ready
    ofmap_writer ofmap_writer_i (
        .clk           (clk),
        .rstn          (rstn),
        .i_ofmap_ready (i_ofmap_ready),
        .o_of_wr       (o_of_wr)
    );

endmodule

// File: writeback/ofmap_writer.sv
`timescale 1ns/1ps

module ofmap_writer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 i_ofmap_ready,
    output mem_ctrl_pkg::of_wr_t o_of_wr
);

    typedef enum logic {
        OF_WAIT,
        OF_WRITE
    } state_t;

    typedef logic [$clog2(mem_ctrl_pkg::OC_TILES)-1:0] oc_t;

    state_t                  state_q;
    state_t                  state_d;
    mem_ctrl_pkg::pix_cnt_t  pix_q;
    oc_t                     oc_q;
    mem_ctrl_pkg::step_cnt_t burst_q;
    mem_ctrl_pkg::of_addr_t  pix_term_q;
    mem_ctrl_pkg::of_addr_t  oc_term_q;
    logic                    pix_last;
    logic                    oc_last;
    logic                    burst_last;
    logic                    oc_en;
    logic                    burst_en;

    assign pix_last   = pix_q == mem_ctrl_pkg::pix_cnt_t'(mem_ctrl_pkg::PIXELS - 1);
    assign oc_last    = oc_q == oc_t'(mem_ctrl_pkg::OC_TILES - 1);
    assign burst_last = burst_q == mem_ctrl_pkg::step_cnt_t'(mem_ctrl_pkg::KERNEL_STEPS - 1);

    assign oc_en    = i_ofmap_ready && pix_last;
    assign burst_en = oc_en && oc_last;  // Last write of a burst

    // Ready low stalls the writer
    assign o_of_wr.wr_en   = i_ofmap_ready;
    assign o_of_wr.wr_done = burst_en && burst_last && (state_q == OF_WRITE);
    assign o_of_wr.addr    = pix_term_q + oc_term_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            OF_WAIT:  if (i_ofmap_ready) state_d = OF_WRITE;
            OF_WRITE: if (burst_en) state_d = OF_WAIT;
            default:  state_d = OF_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q    <= OF_WAIT;
            pix_q      <= '0;
            oc_q       <= '0;
            burst_q    <= '0;
            pix_term_q <= '0;
            oc_term_q  <= '0;
        end else begin
            state_q <= state_d;
            if (i_ofmap_ready) begin
                pix_q      <= pix_last ? '0 : pix_q + mem_ctrl_pkg::pix_cnt_t'(1);
                pix_term_q <= pix_last ? '0 :
                    pix_term_q + mem_ctrl_pkg::of_addr_t'(mem_ctrl_pkg::OF_PIX_STRIDE);
            end
            if (oc_en) begin
                oc_q      <= oc_last ? '0 : oc_q + oc_t'(1);
                oc_term_q <= oc_last ? '0 : oc_term_q + mem_ctrl_pkg::of_addr_t'(1);
            end
            if (burst_en) begin
                burst_q <= burst_last ? '0 : burst_q + mem_ctrl_pkg::step_cnt_t'(1);
            end
        end
    end

endmodule

// File: fetch/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_start,
    input  logic                   i_ofmap_ready,
    input  mem_ctrl_pkg::w_addr_t  i_w_addr,
    input  logic                   i_w_row_last,
    input  mem_ctrl_pkg::if_addr_t i_if_addr,
    input  logic                   i_if_window_last,
    input  logic                   i_if_layer_last,
    output logic                   o_w_step,
    output logic                   o_w_clear,
    output logic                   o_if_step,
    output logic                   o_mac_done,
    output mem_ctrl_pkg::w_rd_t    o_w_rd,
    output mem_ctrl_pkg::if_rd_t   o_if_rd
);

    typedef enum logic [2:0] {
        IDLE,
        W_START,
        W_WAIT,
        W_PREF,
        IF_START,
        IF_FEED
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d          = state_q;
        o_w_step         = 1'b0;
        o_w_clear        = 1'b0;
        o_if_step        = 1'b0;
        o_mac_done       = 1'b0;
        o_w_rd           = '0;
        o_if_rd          = '0;
        o_w_rd.addr      = i_w_addr;
        o_if_rd.addr     = i_if_addr;

        case (state_q)
            IDLE: begin
                if (i_start) begin
                    o_w_clear = 1'b1;  // New layer starts from weight 0
                    state_d   = W_START;
                end
            end
            W_START: begin
                o_w_rd.rd_en    = 1'b1;
                o_w_rd.prefetch = 1'b1;
                o_w_step        = 1'b1;
                state_d         = W_PREF;
            end
            // Hold off the next tile while results drain
            W_WAIT: begin
                if (!i_ofmap_ready) begin
                    o_w_rd.rd_en    = 1'b1;
                    o_w_rd.prefetch = 1'b1;
                    o_w_step        = 1'b1;
                    state_d         = W_PREF;
                end
            end
            W_PREF: begin
                o_w_rd.rd_en = 1'b1;
                o_w_step     = 1'b1;
                if (i_w_row_last) state_d = IF_START;
            end
            IF_START: begin
                o_if_rd.rd_en = 1'b1;
                o_if_rd.start = 1'b1;
                o_if_step     = 1'b1;
                state_d       = IF_FEED;
            end
            IF_FEED: begin
                o_if_rd.rd_en = 1'b1;
                o_if_step     = 1'b1;
                if (i_if_layer_last) begin
                    o_mac_done = 1'b1;
                    state_d    = IDLE;
                end else if (i_if_window_last) begin
                    state_d = W_WAIT;
                end
            end
            default: state_d = IDLE;
        endcase
    end

endmodule

// File: fetch/ifmap_addr_gen.sv
`timescale 1ns/1ps

module ifmap_addr_gen (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_step,
    output mem_ctrl_pkg::if_addr_t o_addr,
    output logic                   o_window_last,
    output logic                   o_layer_last
);

    typedef logic [$clog2(mem_ctrl_pkg::OFMAP_W)-1:0]  x_t;
    typedef logic [$clog2(mem_ctrl_pkg::OFMAP_H)-1:0]  y_t;
    typedef logic [$clog2(mem_ctrl_pkg::OC_TILES)-1:0] oc_t;
    typedef logic [$clog2(mem_ctrl_pkg::IC_TILES)-1:0] ic_t;
    typedef logic [$clog2(mem_ctrl_pkg::KERNEL_W)-1:0] kx_t;
    typedef logic [$clog2(mem_ctrl_pkg::KERNEL_H)-1:0] ky_t;

    x_t                     x_q;
    y_t                     y_q;
    oc_t                    oc_q;
    ic_t                    ic_q;
    kx_t                    kx_q;
    ky_t                    ky_q;
    mem_ctrl_pkg::if_addr_t x_term_q;
    mem_ctrl_pkg::if_addr_t y_term_q;
    mem_ctrl_pkg::if_addr_t ic_term_q;
    mem_ctrl_pkg::if_addr_t kx_term_q;
    mem_ctrl_pkg::if_addr_t ky_term_q;
    logic                   x_last;
    logic                   y_last;
    logic                   oc_last;
    logic                   ic_last;
    logic                   kx_last;
    logic                   ky_last;
    logic                   window_last;
    logic                   y_en;
    logic                   oc_en;
    logic                   ic_en;
    logic                   kx_en;
    logic                   ky_en;

    assign x_last  = x_q == x_t'(mem_ctrl_pkg::OFMAP_W - 1);
    assign y_last  = y_q == y_t'(mem_ctrl_pkg::OFMAP_H - 1);
    assign oc_last = oc_q == oc_t'(mem_ctrl_pkg::OC_TILES - 1);
    assign ic_last = ic_q == ic_t'(mem_ctrl_pkg::IC_TILES - 1);
    assign kx_last = kx_q == kx_t'(mem_ctrl_pkg::KERNEL_W - 1);
    assign ky_last = ky_q == ky_t'(mem_ctrl_pkg::KERNEL_H - 1);

    // Innermost to outermost: x, y, oc tile, ic tile, kx, ky
    assign y_en  = i_step && x_last;
    assign oc_en = y_en && y_last;
    assign ic_en = oc_en && oc_last;
    assign kx_en = ic_en && ic_last;
    assign ky_en = kx_en && kx_last;

    assign window_last   = x_last && y_last;
    assign o_window_last = window_last;
    assign o_layer_last  = window_last && oc_last && ic_last && kx_last && ky_last;

    // Oc tile reuses the same ifmap window, so it adds no term
    assign o_addr = x_term_q + kx_term_q + y_term_q + ky_term_q + ic_term_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            x_q       <= '0;
            y_q       <= '0;
            oc_q      <= '0;
            ic_q      <= '0;
            kx_q      <= '0;
            ky_q      <= '0;
            x_term_q  <= '0;
            y_term_q  <= '0;
            ic_term_q <= '0;
            kx_term_q <= '0;
            ky_term_q <= '0;
        end else begin
            if (i_step) begin
                x_q      <= x_last ? '0 : x_q + x_t'(1);
                x_term_q <= x_last ? '0 : x_term_q + mem_ctrl_pkg::if_addr_t'(1);
            end
            if (y_en) begin
                y_q      <= y_last ? '0 : y_q + y_t'(1);
                y_term_q <= y_last ? '0 :
                    y_term_q + mem_ctrl_pkg::if_addr_t'(mem_ctrl_pkg::IF_ROW_STRIDE);
            end
            if (oc_en) oc_q <= oc_last ? '0 : oc_q + oc_t'(1);
            if (ic_en) begin
                ic_q      <= ic_last ? '0 : ic_q + ic_t'(1);
                ic_term_q <= ic_last ? '0 :
                    ic_term_q + mem_ctrl_pkg::if_addr_t'(mem_ctrl_pkg::IF_TILE_STRIDE);
            end
            if (kx_en) begin
                kx_q      <= kx_last ? '0 : kx_q + kx_t'(1);
                kx_term_q <= kx_last ? '0 : kx_term_q + mem_ctrl_pkg::if_addr_t'(1);
            end
            if (ky_en) begin
                ky_q      <= ky_last ? '0 : ky_q + ky_t'(1);  // Wraps to 0 after the layer
                ky_term_q <= ky_last ? '0 :
                    ky_term_q + mem_ctrl_pkg::if_addr_t'(mem_ctrl_pkg::IF_ROW_STRIDE);
            end
        end
    end

endmodule

// File: fetch/weight_addr_gen.sv
`timescale 1ns/1ps

module weight_addr_gen (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_step,
    input  logic                  i_clear,
    output mem_ctrl_pkg::w_addr_t o_addr,
    output logic                  o_row_last
);

    typedef logic [$clog2(mem_ctrl_pkg::MAC_ROW)-1:0]  row_t;
    typedef logic [$clog2(mem_ctrl_pkg::OC_TILES)-1:0] oc_t;

    row_t                    row_q;
    oc_t                     oc_q;
    mem_ctrl_pkg::step_cnt_t step_q;
    mem_ctrl_pkg::w_addr_t   row_term_q;
    mem_ctrl_pkg::w_addr_t   oc_term_q;
    mem_ctrl_pkg::w_addr_t   step_term_q;
    logic                    row_last;
    logic                    oc_last;
    logic                    step_last;
    logic                    oc_en;
    logic                    step_en;

    assign row_last  = row_q == row_t'(mem_ctrl_pkg::MAC_ROW - 1);
    assign oc_last   = oc_q == oc_t'(mem_ctrl_pkg::OC_TILES - 1);
    assign step_last = step_q == mem_ctrl_pkg::step_cnt_t'(mem_ctrl_pkg::KERNEL_STEPS - 1);

    // Carry chain: row -> oc tile -> kernel step
    assign oc_en   = i_step && row_last;
    assign step_en = oc_en && oc_last;

    assign o_row_last = row_last;
    assign o_addr     = row_term_q + oc_term_q + step_term_q;

    always_ff @(posedge clk) begin
        if (!rstn || i_clear) begin
            row_q       <= '0;
            oc_q        <= '0;
            step_q      <= '0;
            row_term_q  <= '0;
            oc_term_q   <= '0;
            step_term_q <= '0;
        end else begin
            if (i_step) begin
                row_q      <= row_last ? '0 : row_q + row_t'(1);
                row_term_q <= row_last ? '0 :
                    row_term_q + mem_ctrl_pkg::w_addr_t'(mem_ctrl_pkg::WT_ROW_STRIDE);
            end
            if (oc_en) begin
                oc_q      <= oc_last ? '0 : oc_q + oc_t'(1);
                oc_term_q <= oc_last ? '0 : oc_term_q + mem_ctrl_pkg::w_addr_t'(1);
            end
            if (step_en) begin
                step_q      <= step_last ? '0 : step_q + mem_ctrl_pkg::step_cnt_t'(1);
                step_term_q <= step_last ? '0 :
                    step_term_q + mem_ctrl_pkg::w_addr_t'(mem_ctrl_pkg::WT_STEP_STRIDE);
            end
        end
    end

endmodule

// File: common/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // MAC array geometry
    localparam int MAC_ROW = 4;
    localparam int MAC_COL = 4;

    // Layer shape
    localparam int OFMAP_W  = 4;
    localparam int OFMAP_H  = 4;
    localparam int IFMAP_W  = 6;
    localparam int KERNEL_W = 3;
    localparam int KERNEL_H = 3;
    localparam int IN_CH    = 8;
    localparam int OUT_CH   = 8;

    localparam int OC_TILES     = OUT_CH / MAC_COL;
    localparam int IC_TILES     = IN_CH / MAC_ROW;
    localparam int KERNEL_STEPS = KERNEL_W * KERNEL_H * IC_TILES;  // Also number of bursts
    localparam int PASSES       = OC_TILES * KERNEL_STEPS;
    localparam int PIXELS       = OFMAP_W * OFMAP_H;

    // Strides chosen so each memory is densely packed
    localparam int WT_ROW_STRIDE  = OC_TILES;
    localparam int WT_STEP_STRIDE = MAC_ROW * OC_TILES;
    localparam int IF_ROW_STRIDE  = IFMAP_W;
    localparam int IF_TILE_STRIDE = IFMAP_W * IFMAP_W;
    localparam int OF_PIX_STRIDE  = OC_TILES;

    typedef logic [7:0] w_addr_t;
    typedef logic [6:0] if_addr_t;
    typedef logic [4:0] of_addr_t;

    typedef logic [4:0] step_cnt_t;
    typedef logic [3:0] pix_cnt_t;

    typedef struct packed {
        logic    rd_en;
        logic    prefetch;  // First row of a weight tile
        w_addr_t addr;
    } w_rd_t;

    typedef struct packed {
        logic     rd_en;
        logic     start;    // First read of a window
        if_addr_t addr;
    } if_rd_t;

    typedef struct packed {
        logic     wr_en;
        logic     wr_done;
        of_addr_t addr;
    } of_wr_t;

endpackage
